// File: list.f
source/histPkg.sv
source/hitBus.sv
source/photonSampler.sv
source/hitFifo.sv
source/histBuilder.sv
source/histRam.sv
source/histTop.sv
verification/tbClock.sv
verification/histTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the histogram testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module histTb -f list.f --Mdir build -o histSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./build/histSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: source/histBuilder.sv
`default_nettype none

module histBuilder import histPkg::*; #(
    parameter int PIXEL_NUM = DEF_PIXEL_NUM,
    parameter int BIN_NUM = DEF_BIN_NUM,
    parameter int COUNT_W = DEF_COUNT_W,
    localparam int DEPTH = PIXEL_NUM * BIN_NUM,
    localparam int ADDR_W = hitWordW(PIXEL_NUM, BIN_NUM)
) (
    input logic clk,
    input logic res,
    input logic start,
    input logic [RUN_W-1:0] runLength,
    output logic busy,
    output logic runDone,
    hitBus.master wb,
    output logic ramWe,
    output logic [ADDR_W-1:0] ramWaddr,
    output logic [COUNT_W-1:0] ramWdata,
    output logic ramRe,
    output logic [ADDR_W-1:0] ramRaddr,
    input logic [COUNT_W-1:0] ramRdata,
    input logic rdEn,
    input logic [ADDR_W-1:0] rdAddr
);

    builderStateT state;
    builderStateT nextState;

    // run bookkeeping
    logic [RUN_W-1:0] runLenQ;
    logic [RUN_W-1:0] takenCnt;
    logic [ADDR_W-1:0] clrAddr;
    logic hostSel;
    logic wantHit;

    // stage 1, ram data for this hit arrives now
    logic s1Valid;
    logic [ADDR_W-1:0] s1Addr;

    // write retired at the last edge
    // a read issued in that cycle missed it
    logic lastWe;
    logic [ADDR_W-1:0] lastWaddr;
    logic [COUNT_W-1:0] lastWdata;

    logic [COUNT_W-1:0] curVal;
    logic [COUNT_W-1:0] incVal;

    always_comb begin
        nextState = state;
        case (state)
            IDLE, DONE: begin
                if (start) begin
                    nextState = CLEAR;
                end
            end
            CLEAR: begin
                // one zero write per address
                if (clrAddr == ADDR_W'(DEPTH - 1)) begin
                    nextState = BUILD;
                end
            end
            BUILD: begin
                if (takenCnt == runLenQ) begin
                    nextState = DRAIN;
                end
            end
            DRAIN: begin
                // pipe empty, last write is in the ram
                if (!s1Valid && !ramWe) begin
                    nextState = DONE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    assign busy = state == CLEAR || state == BUILD || state == DRAIN;
    assign runDone = state == DONE;
    // host owns the read port between runs
    assign hostSel = state == IDLE || state == DONE;
    assign wantHit = state == BUILD && takenCnt != runLenQ;

    // read cycles toward the fifo
    assign wb.cyc = wantHit;
    assign wb.stb = wantHit;
    assign wb.we = 1'b0;
    assign wb.adr = '0;
    assign wb.datW = '0;

    // stage 0, accepted hit addresses the ram directly
    assign ramRe = hostSel ? rdEn : wb.ack;
    assign ramRaddr = hostSel ? rdAddr : wb.datR;

    // forward newest first
    always_comb begin
        if (ramWe && ramWaddr == s1Addr) begin
            curVal = ramWdata;
        end else if (lastWe && lastWaddr == s1Addr) begin
            curVal = lastWdata;
        end else begin
            curVal = ramRdata;
        end
    end

    // saturate at all ones
    assign incVal = (&curVal) ? curVal : curVal + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            runLenQ <= '0;
            takenCnt <= '0;
            clrAddr <= '0;
            s1Valid <= 1'b0;
            ramWe <= 1'b0;
            lastWe <= 1'b0;
        end else begin
            if (hostSel && start) begin
                runLenQ <= runLength;
                takenCnt <= '0;
            end else if (wb.ack) begin
                takenCnt <= takenCnt + 1'b1;
            end
            if (state == CLEAR) begin
                clrAddr <= clrAddr + 1'b1;
            end else begin
                clrAddr <= '0;
            end
            s1Valid <= wb.ack;
            // stage 2, clear or increment write
            ramWe <= state == CLEAR || s1Valid;
            lastWe <= ramWe;
        end
    end

    always_ff @(posedge clk) begin
        if (wb.ack) begin
            s1Addr <= wb.datR;
        end
        if (state == CLEAR) begin
            ramWaddr <= clrAddr;
            ramWdata <= '0;
        end else begin
            ramWaddr <= s1Addr;
            ramWdata <= incVal;
        end
        lastWaddr <= ramWaddr;
        lastWdata <= ramWdata;
    end

endmodule

`default_nettype wire

// File: source/histPkg.sv
`default_nettype none

package histPkg;

    // default array geometry, overridden from the top level
    localparam int DEF_PIXEL_NUM = 4;
    localparam int DEF_BIN_NUM = 16;
    // bin counter width, saturates at all ones
    localparam int DEF_COUNT_W = 8;
    localparam int DEF_FIFO_DEPTH = 8;

    // extra bin bit so out-of-range bins reach the sampler
    localparam int BIN_GUARD = 1;
    // hits per run from the host
    localparam int RUN_W = 16;
    // dropped-bin counter
    localparam int OVER_W = 8;
    // bus address field, single-register slaves
    localparam int BUS_ADR_W = 4;

    // flat hit word, pixel then bin
    function automatic int hitWordW(int pixelNum, int binNum);
        return $clog2(pixelNum * binNum);
    endfunction

    // bin field as seen at the pins
    function automatic int binFieldW(int binNum);
        return $clog2(binNum) + BIN_GUARD;
    endfunction

    // builder sequencing
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        BUILD,
        DRAIN,
        DONE
    } builderStateT;

endpackage

`default_nettype wire

// File: source/histRam.sv
`default_nettype none

module histRam import histPkg::*; #(
    parameter int DEPTH = DEF_PIXEL_NUM * DEF_BIN_NUM,
    parameter int COUNT_W = DEF_COUNT_W,
    localparam int AW = $clog2(DEPTH)
) (
    input logic clk,
    input logic we,
    input logic [AW-1:0] waddr,
    input logic [COUNT_W-1:0] wdata,
    input logic re,
    input logic [AW-1:0] raddr,
    output logic [COUNT_W-1:0] rdata
);

    // one counter per pixel and bin
    logic [COUNT_W-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read port
    // same-address write at the same edge returns the old count
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// File: source/histTop.sv
`default_nettype none

module histTop import histPkg::*; #(
    parameter int PIXEL_NUM = DEF_PIXEL_NUM,
    parameter int BIN_NUM = DEF_BIN_NUM,
    parameter int COUNT_W = DEF_COUNT_W,
    parameter int FIFO_DEPTH = DEF_FIFO_DEPTH,
    localparam int PIXEL_W = $clog2(PIXEL_NUM),
    localparam int BIN_W = binFieldW(BIN_NUM),
    localparam int ADDR_W = hitWordW(PIXEL_NUM, BIN_NUM)
) (
    input logic clk,
    input logic res,
    input logic hitValid,
    input logic [PIXEL_W-1:0] hitPixel,
    input logic [BIN_W-1:0] hitBin,
    output logic hitReady,
    input logic start,
    input logic [RUN_W-1:0] runLength,
    input logic rdEn,
    input logic [ADDR_W-1:0] rdAddr,
    output logic [COUNT_W-1:0] rdData,
    output logic busy,
    output logic runDone,
    output logic [OVER_W-1:0] overRange
);

    // builder to ram
    logic ramWe;
    logic [ADDR_W-1:0] ramWaddr;
    logic [COUNT_W-1:0] ramWdata;
    logic ramRe;
    logic [ADDR_W-1:0] ramRaddr;

    // sampler to fifo
    hitBus #(.DAT_W(ADDR_W)) linkA ();
    // fifo to builder
    hitBus #(.DAT_W(ADDR_W)) linkB ();

    photonSampler #(
        .PIXEL_NUM(PIXEL_NUM),
        .BIN_NUM(BIN_NUM)
    ) i_photonSampler (
        .clk(clk),
        .res(res),
        .hitValid(hitValid),
        .hitPixel(hitPixel),
        .hitBin(hitBin),
        .hitReady(hitReady),
        .overRange(overRange),
        .wb(linkA.master)
    );

    hitFifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .ADDR_W(ADDR_W)
    ) i_hitFifo (
        .clk(clk),
        .res(res),
        .wr(linkA.slave),
        .rd(linkB.slave)
    );

    histBuilder #(
        .PIXEL_NUM(PIXEL_NUM),
        .BIN_NUM(BIN_NUM),
        .COUNT_W(COUNT_W)
    ) i_histBuilder (
        .clk(clk),
        .res(res),
        .start(start),
        .runLength(runLength),
        .busy(busy),
        .runDone(runDone),
        .wb(linkB.master),
        .ramWe(ramWe),
        .ramWaddr(ramWaddr),
        .ramWdata(ramWdata),
        .ramRe(ramRe),
        .ramRaddr(ramRaddr),
        .ramRdata(rdData),
        .rdEn(rdEn),
        .rdAddr(rdAddr)
    );

    // host readout shares the ram read data
    histRam #(
        .DEPTH(PIXEL_NUM * BIN_NUM),
        .COUNT_W(COUNT_W)
    ) i_histRam (
        .clk(clk),
        .we(ramWe),
        .waddr(ramWaddr),
        .wdata(ramWdata),
        .re(ramRe),
        .raddr(ramRaddr),
        .rdata(rdData)
    );

endmodule

`default_nettype wire

// File: source/hitBus.sv
`default_nettype none

interface hitBus import histPkg::*; #(
    parameter int DAT_W = hitWordW(DEF_PIXEL_NUM, DEF_BIN_NUM)
);

    // cycle qualifiers, held by the master until ack
    logic cyc;
    logic stb;
    logic we;
    // always zero, one register per slave
    logic [BUS_ADR_W-1:0] adr;
    // hit word on writes
    logic [DAT_W-1:0] datW;
    // hit word on reads, valid with ack
    logic [DAT_W-1:0] datR;
    // single-cycle handshake
    logic ack;

    modport master (
        output cyc, stb, we, adr, datW,
        input ack, datR
    );

    modport slave (
        input cyc, stb, we, adr, datW,
        output ack, datR
    );

endinterface

`default_nettype wire

// File: source/hitFifo.sv
`default_nettype none

module hitFifo import histPkg::*; #(
    parameter int FIFO_DEPTH = DEF_FIFO_DEPTH,
    parameter int ADDR_W = hitWordW(DEF_PIXEL_NUM, DEF_BIN_NUM)
) (
    input logic clk,
    input logic res,
    hitBus.slave wr,
    hitBus.slave rd
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [ADDR_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic full;
    logic empty;
    logic push;
    logic pop;
    logic wrAck;

    // wrap at the last entry, any depth
    function automatic logic [PTR_W-1:0] nextPtr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = count == CNT_W'(FIFO_DEPTH);
    assign empty = count == '0;

    // write side
    // entry stored at the stb edge, ack follows one cycle later
    assign push = wr.cyc && wr.stb && wr.we && !wrAck && !full;
    assign wr.ack = wrAck;
    // nothing to return on the write link
    assign wr.datR = '0;

    // read side
    // ack straight from occupancy, data valid with it
    assign pop = rd.cyc && rd.stb && !rd.we && !empty;
    assign rd.ack = pop;
    assign rd.datR = mem[rdPtr];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrAck <= 1'b0;
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            // single-cycle ack, master drops stb on it
            wrAck <= push;
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // occupancy, simultaneous push and pop cancel
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= wr.datW;
        end
    end

endmodule

`default_nettype wire

// File: source/photonSampler.sv
`default_nettype none

module photonSampler import histPkg::*; #(
    parameter int PIXEL_NUM = DEF_PIXEL_NUM,
    parameter int BIN_NUM = DEF_BIN_NUM,
    localparam int PIXEL_W = $clog2(PIXEL_NUM),
    localparam int BIN_W = binFieldW(BIN_NUM),
    localparam int ADDR_W = hitWordW(PIXEL_NUM, BIN_NUM)
) (
    input logic clk,
    input logic res,
    input logic hitValid,
    input logic [PIXEL_W-1:0] hitPixel,
    input logic [BIN_W-1:0] hitBin,
    output logic hitReady,
    output logic [OVER_W-1:0] overRange,
    hitBus.master wb
);

    // one hit held until the fifo takes it
    logic pending;
    logic [ADDR_W-1:0] hitWord;
    logic take;
    logic inRange;

    // back-pressure while a bus cycle is open
    assign hitReady = !pending;
    assign take = hitValid && hitReady;
    // guard bit or index past the last bin
    assign inRange = hitBin < BIN_W'(BIN_NUM);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pending <= 1'b0;
        end else if (take && inRange) begin
            pending <= 1'b1;
        end else if (pending && wb.ack) begin
            // cycle ends at the ack edge
            pending <= 1'b0;
        end
    end

    // out-of-range hits are only counted
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            overRange <= '0;
        end else if (take && !inRange && overRange != '1) begin
            overRange <= overRange + 1'b1;
        end
    end

    // flat ram address, pixel * BIN_NUM + bin
    always_ff @(posedge clk) begin
        if (take && inRange) begin
            hitWord <= ADDR_W'(hitPixel) * ADDR_W'(BIN_NUM) + ADDR_W'(hitBin);
        end
    end

    // write cycle toward the fifo
    assign wb.cyc = pending;
    assign wb.stb = pending;
    assign wb.we = pending;
    assign wb.adr = '0;
    assign wb.datW = hitWord;

endmodule

`default_nettype wire

// File: verification/histTb.sv
`default_nettype none

module histTb import histPkg::*; ();

    localparam int PIXEL_NUM = DEF_PIXEL_NUM;
    localparam int BIN_NUM = DEF_BIN_NUM;
    localparam int COUNT_W = DEF_COUNT_W;
    localparam int DEPTH = PIXEL_NUM * BIN_NUM;
    localparam int ADDR_W = hitWordW(PIXEL_NUM, BIN_NUM);
    localparam int COUNT_MAX = (1 << COUNT_W) - 1;
    // hit total over all runs
    // budget per hit plus clear, drain and readout per run
    localparam int TOTAL_HITS = 0 + 200 + 404 + 40 + 30 + 50;
    localparam int RUNS = 6;
    localparam int WATCHDOG_CYCLES = TOTAL_HITS * 10 + RUNS * (DEPTH * 3 + 10) + 100;

    logic clk;
    logic res;
    logic hitValid;
    logic [$clog2(PIXEL_NUM)-1:0] hitPixel;
    logic [binFieldW(BIN_NUM)-1:0] hitBin;
    logic hitReady;
    logic start;
    logic [RUN_W-1:0] runLength;
    logic rdEn;
    logic [ADDR_W-1:0] rdAddr;
    logic [COUNT_W-1:0] rdData;
    logic busy;
    logic runDone;
    logic [OVER_W-1:0] overRange;

    // reference model and check state
    int refHist [DEPTH];
    logic [OVER_W-1:0] overExp;
    logic rdPend;
    logic [COUNT_W-1:0] rdExp;
    int rdExpAddr;
    logic [31:0] lfsr;
    int valErrs;
    int otherErrs;
    int lowRun;
    int maxLow;

    tbClock #(.PERIOD(40), .RESET_CYCLES(10)) i_tbClock (.clk(clk), .res(res));

    histTop i_histTop (
        .clk(clk), .res(res),
        .hitValid(hitValid), .hitPixel(hitPixel), .hitBin(hitBin), .hitReady(hitReady),
        .start(start), .runLength(runLength),
        .rdEn(rdEn), .rdAddr(rdAddr), .rdData(rdData),
        .busy(busy), .runDone(runDone), .overRange(overRange)
    );

    // idle outputs right after reset release
    resetState: assert property (@(posedge clk) $rose(res) |-> !busy && !runDone && hitReady)
        else begin
            otherErrs++;
            $display("busy, runDone or hitReady wrong right after reset at %0t", $time);
        end

    overMatch: assert property (@(posedge clk) disable iff (!res) overRange == overExp)
        else begin
            valErrs++;
            $display("FAIL %0t overRange expected %0d got %0d",
                $time, $sampled(overExp), $sampled(overRange));
        end

    doneHold: assert property (@(posedge clk) disable iff (!res) runDone && !start |=> runDone)
        else begin
            otherErrs++;
            $display("runDone dropped without a new start at %0t", $time);
        end

    busyDone: assert property (@(posedge clk) disable iff (!res) !(busy && runDone))
        else begin
            otherErrs++;
            $display("busy and runDone both high at %0t", $time);
        end

    // busy from the cycle after start until runDone takes over
    busyRun: assert property (@(posedge clk) disable iff (!res)
        start || busy |=> busy != runDone)
        else begin
            otherErrs++;
            $display("busy did not cover the run up to runDone at %0t", $time);
        end

    // rdData compared one cycle after rdEn
    rdCheck: assert property (@(posedge clk) rdPend |-> rdData == rdExp)
        else begin
            valErrs++;
            $display("FAIL %0t rdData[%0d] expected %0d got %0d",
                $time, $sampled(rdExpAddr), $sampled(rdExp), $sampled(rdData));
        end

    // longest stretch of a held hit that the sampler refused
    always @(negedge clk) begin
        if (hitValid && !hitReady) begin
            lowRun = lowRun + 1;
        end else begin
            lowRun = 0;
        end
        if (lowRun > maxLow) begin
            maxLow = lowRun;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic drawBits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // reference starts from zero for a new run
    task automatic startRun(input int n);
        for (int a = 0; a < DEPTH; a++) begin
            refHist[a] = 0;
        end
        start = 1'b1;
        runLength = RUN_W'(n);
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    // hold the hit until taken and idle for gap cycles afterwards
    task automatic sendHit(input int pix, input int bin, input int gap);
        int idx;
        hitValid = 1'b1;
        hitPixel = pix[$clog2(PIXEL_NUM)-1:0];
        hitBin = bin[binFieldW(BIN_NUM)-1:0];
        @(negedge clk);
        while (!hitReady) @(negedge clk);
        @(posedge clk);
        #2;
        hitValid = 1'b0;
        if (bin < BIN_NUM) begin
            idx = pix * BIN_NUM + bin;
            if (refHist[idx] < COUNT_MAX) begin
                refHist[idx] = refHist[idx] + 1;
            end
        end else begin
            overExp = overExp + 1'b1;
        end
        for (int g = 0; g < gap; g++) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic randomHits(input int n, input bit gaps);
        int pix;
        int bin;
        int gap;
        for (int i = 0; i < n; i++) begin
            drawBits(2, pix);
            drawBits(4, bin);
            gap = 0;
            if (gaps) begin
                drawBits(2, gap);
            end
            sendHit(pix, bin, gap);
        end
    endtask

    task automatic waitDone();
        while (!runDone) @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    // pipelined readout of every bin
    task automatic readAll();
        for (int a = 0; a <= DEPTH; a++) begin
            rdPend = a > 0;
            rdExpAddr = a - 1;
            rdExp = (a > 0) ? COUNT_W'(refHist[a-1]) : '0;
            rdEn = a < DEPTH;
            rdAddr = ADDR_W'(a);
            @(posedge clk);
            #2;
        end
        rdPend = 1'b0;
        rdEn = 1'b0;
    endtask

    // hung run guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, run hung after %0d cycles", WATCHDOG_CYCLES);
        $display("value errors %0d, other errors %0d", valErrs, otherErrs + 1);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int pix;
        int bin;
        hitValid = 1'b0;
        hitPixel = '0;
        hitBin = '0;
        start = 1'b0;
        runLength = '0;
        rdEn = 1'b0;
        rdAddr = '0;
        rdPend = 1'b0;
        rdExp = '0;
        rdExpAddr = 0;
        overExp = '0;
        lfsr = 32'h385c;
        valErrs = 0;
        otherErrs = 0;
        lowRun = 0;
        maxLow = 0;
        @(posedge res);
        @(posedge clk);
        #2;
        // empty run leaves all bins at zero
        startRun(0);
        waitDone();
        readAll();
        // random hits with random spacing
        startRun(200);
        randomHits(200, 1'b1);
        waitDone();
        readAll();
        // same bin back to back gives the exact count and then saturates
        startRun(404);
        // two bins alternating in the backlog
        for (int i = 0; i < 4; i++) begin
            sendHit(1, (i % 2 == 0) ? 6 : 5, 0);
        end
        for (int i = 0; i < 100; i++) begin
            sendHit(1, 5, 0);
        end
        for (int i = 0; i < 300; i++) begin
            sendHit(2, 9, 0);
        end
        waitDone();
        readAll();
        // burst during clear fills the fifo
        maxLow = 0;
        startRun(40);
        randomHits(40, 1'b0);
        waitDone();
        readAll();
        assert (maxLow >= 4)
            else begin
                otherErrs++;
                $display("hitReady never stayed low while the FIFO was full");
            end
        // every third hit past the last bin
        startRun(20);
        for (int i = 0; i < 30; i++) begin
            drawBits(2, pix);
            drawBits(4, bin);
            if (i % 3 == 2) begin
                bin = bin + BIN_NUM;
            end
            sendHit(pix, bin, 1);
        end
        waitDone();
        readAll();
        // restart clears the old histogram
        startRun(50);
        randomHits(50, 1'b1);
        waitDone();
        readAll();
        $display("value errors %0d, other errors %0d", valErrs, otherErrs);
        if (valErrs + otherErrs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tbClock.sv
`default_nettype none

module tbClock #(
    parameter int PERIOD = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic res
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        res = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
    end

endmodule

`default_nettype wire
